/* logic/bus_pkg.sv */
// ------------------------------
// Host bus types: widths, request
// and response words, link select
// ------------------------------

package bus_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;
  localparam int unsigned MaskWidth = DataWidth / 8;

  // Byte offset inside one data word
  localparam int unsigned ByteOffsetWidth = $clog2(MaskWidth);

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [MaskWidth-1:0] wmask_t;

  typedef struct packed {
    logic   we;
    addr_t  addr;
    wmask_t wmask;
    data_t  wdata;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    LINK_MEM,
    LINK_IO,
    LINK_NONE
  } link_e;

endpackage

/* logic/bram_pkg.sv */
// ------------------------------
// BRAM side command and bridge FSM
// ------------------------------

package bram_pkg;

  import bus_pkg::*;

  typedef struct packed {
    logic   we;
    wmask_t wmask;
    data_t  wdata;
  } bram_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK,
    RELEASE
  } bridge_state_e;

endpackage

/* logic/bus_socket_1n.sv */
// ------------------------------
// 1-to-2 socket: address decode,
// link steering and error reply
// ------------------------------

`timescale 1ns/1ps

module bus_socket_1n import bus_pkg::*, bram_pkg::*; #(
  parameter addr_t MemBase = 32'h8000_0000,
  parameter addr_t MemMask = 32'h0000_FFFF,
  parameter addr_t IoBase  = 32'h8001_0000,
  parameter addr_t IoMask  = 32'h0000_003F
) (
  input  logic      clk_i,
  input  logic      rst_i,

  input  logic      req_i,
  input  bus_req_t  req_data_i,
  output logic      ack_o,
  output bus_rsp_t  rsp_o,

  output logic      mem_req_o,
  output bram_cmd_t mem_cmd_o,
  output addr_t     mem_addr_o,
  input  logic      mem_ack_i,
  input  data_t     mem_rdata_i,

  output logic      io_req_o,
  output bram_cmd_t io_cmd_o,
  output addr_t     io_addr_o,
  input  logic      io_ack_i,
  input  data_t     io_rdata_i
);

  logic      io_hit;
  logic      mem_hit;
  link_e     link_d;
  link_e     link_q;
  logic      busy_q;
  logic      err_ack_q;
  logic      ack_sel;
  bram_cmd_t cmd;

  // IO window wins when both match
  assign io_hit  = ((req_data_i.addr ^ IoBase) & ~IoMask) == '0;
  assign mem_hit = ((req_data_i.addr ^ MemBase) & ~MemMask) == '0;
  assign link_d  = io_hit ? LINK_IO : (mem_hit ? LINK_MEM : LINK_NONE);

  always_comb
  begin
    cmd.we    = req_data_i.we;
    cmd.wmask = req_data_i.wmask;
    cmd.wdata = req_data_i.wdata;
  end

  assign mem_req_o  = busy_q && (link_q == LINK_MEM) && req_i;
  assign mem_cmd_o  = (link_q == LINK_MEM) ? cmd : '0;
  assign mem_addr_o = (link_q == LINK_MEM) ? req_data_i.addr : '0;

  assign io_req_o  = busy_q && (link_q == LINK_IO) && req_i;
  assign io_cmd_o  = (link_q == LINK_IO) ? cmd : '0;
  assign io_addr_o = (link_q == LINK_IO) ? req_data_i.addr : '0;

  always_comb
  begin
    case (link_q)
      LINK_MEM:
      begin
        ack_sel     = mem_ack_i;
        rsp_o.rdata = mem_rdata_i;
      end
      LINK_IO:
      begin
        ack_sel     = io_ack_i;
        rsp_o.rdata = io_rdata_i;
      end
      default:
      begin
        ack_sel     = err_ack_q;
        rsp_o.rdata = '0;
      end
    endcase
    rsp_o.err = err_ack_q;
  end

  assign ack_o = ack_sel;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      busy_q    <= 1'b0;
      link_q    <= LINK_NONE;
      err_ack_q <= 1'b0;
    end
    else
    begin
      if (!busy_q)
      begin
        if (req_i)
        begin
          busy_q <= 1'b1;
          link_q <= link_d;
        end
      end
      else if (!req_i && ack_sel)
      begin
        // Selected link drops its ack on this same edge
        busy_q <= 1'b0;
        link_q <= LINK_NONE;
      end
      // Local responder for unmapped addresses
      if (busy_q && (link_q == LINK_NONE))
        err_ack_q <= req_i;
    end
  end

endmodule

/* logic/bram_bridge.sv */
// ------------------------------
// Link request to one-cycle BRAM
// access with four-phase ack
// ------------------------------

`timescale 1ns/1ps

module bram_bridge import bus_pkg::*, bram_pkg::*; #(
  parameter int unsigned BramAddrWidth = 13
) (
  input  logic                     clk_i,
  input  logic                     rst_i,

  input  logic                     req_i,
  input  bram_cmd_t                cmd_i,
  input  addr_t                    addr_i,
  output logic                     ack_o,
  output data_t                    rdata_o,

  output logic                     bram_en_o,
  output logic                     bram_we_o,
  output logic [BramAddrWidth-1:0] bram_addr_o,
  output wmask_t                   bram_wmask_o,
  output data_t                    bram_wdata_o,
  input  data_t                    bram_rdata_i
);

  bridge_state_e            state_q;
  logic                     en_q;
  logic                     we_q;
  logic [BramAddrWidth-1:0] addr_q;
  wmask_t                   wmask_q;
  data_t                    wdata_q;
  data_t                    rdata_q;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q <= IDLE;
      en_q    <= 1'b0;
      we_q    <= 1'b0;
    end
    else
    begin
      case (state_q)
        IDLE:
          if (req_i)
          begin
            state_q <= ACCESS;
            en_q    <= 1'b1;
            we_q    <= cmd_i.we;
          end
        // First cycle drives en, second waits on read latency
        ACCESS:
        begin
          en_q <= 1'b0;
          we_q <= 1'b0;
          if (!en_q)
            state_q <= ACK;
        end
        ACK:
          if (!req_i)
            state_q <= RELEASE;
        default:
          state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if ((state_q == IDLE) && req_i)
    begin
      addr_q  <= addr_i[ByteOffsetWidth +: BramAddrWidth];
      wmask_q <= cmd_i.wmask;
      wdata_q <= cmd_i.wdata;
    end
    if ((state_q == ACCESS) && !en_q)
      rdata_q <= bram_rdata_i;
  end

  assign ack_o        = (state_q == ACK);
  assign rdata_o      = rdata_q;
  assign bram_en_o    = en_q;
  assign bram_we_o    = we_q;
  assign bram_addr_o  = addr_q;
  assign bram_wmask_o = wmask_q;
  assign bram_wdata_o = wdata_q;

endmodule

/* logic/core_mem_wrapper.sv */
// ------------------------------
// Memory side of the core wrapper
// ------------------------------

`timescale 1ns/1ps

module core_mem_wrapper import bus_pkg::*, bram_pkg::*; #(
  parameter addr_t       MemBase       = 32'h8000_0000,
  parameter addr_t       MemMask       = 32'h0000_FFFF,
  parameter addr_t       IoBase        = 32'h8001_0000,
  parameter addr_t       IoMask        = 32'h0000_003F,
  parameter int unsigned BramAddrWidth = 13
) (
  input  logic                     clk_i,
  input  logic                     rst_i,

  input  logic                     req_i,
  input  bus_req_t                 req_data_i,
  output logic                     ack_o,
  output bus_rsp_t                 rsp_o,

  output logic                     mem_en_o,
  output logic                     mem_we_o,
  output logic [BramAddrWidth-1:0] mem_addr_o,
  output wmask_t                   mem_wmask_o,
  output data_t                    mem_wdata_o,
  input  data_t                    mem_rdata_i,

  output logic                     io_en_o,
  output logic                     io_we_o,
  output logic [BramAddrWidth-1:0] io_addr_o,
  output wmask_t                   io_wmask_o,
  output data_t                    io_wdata_o,
  input  data_t                    io_rdata_i
);

  logic      mem_req;
  bram_cmd_t mem_cmd;
  addr_t     mem_addr;
  logic      mem_ack;
  data_t     mem_link_rdata;

  logic      io_req;
  bram_cmd_t io_cmd;
  addr_t     io_addr;
  logic      io_ack;
  data_t     io_link_rdata;

  bus_socket_1n #(
    .MemBase (MemBase),
    .MemMask (MemMask),
    .IoBase  (IoBase),
    .IoMask  (IoMask)
  ) socket_1n (
    .clk_i,
    .rst_i,
    .req_i,
    .req_data_i,
    .ack_o,
    .rsp_o,
    .mem_req_o   (mem_req),
    .mem_cmd_o   (mem_cmd),
    .mem_addr_o  (mem_addr),
    .mem_ack_i   (mem_ack),
    .mem_rdata_i (mem_link_rdata),
    .io_req_o    (io_req),
    .io_cmd_o    (io_cmd),
    .io_addr_o   (io_addr),
    .io_ack_i    (io_ack),
    .io_rdata_i  (io_link_rdata)
  );

  bram_bridge #(
    .BramAddrWidth (BramAddrWidth)
  ) mem_bridge (
    .clk_i,
    .rst_i,
    .req_i        (mem_req),
    .cmd_i        (mem_cmd),
    .addr_i       (mem_addr),
    .ack_o        (mem_ack),
    .rdata_o      (mem_link_rdata),
    .bram_en_o    (mem_en_o),
    .bram_we_o    (mem_we_o),
    .bram_addr_o  (mem_addr_o),
    .bram_wmask_o (mem_wmask_o),
    .bram_wdata_o (mem_wdata_o),
    .bram_rdata_i (mem_rdata_i)
  );

  bram_bridge #(
    .BramAddrWidth (BramAddrWidth)
  ) io_bridge (
    .clk_i,
    .rst_i,
    .req_i        (io_req),
    .cmd_i        (io_cmd),
    .addr_i       (io_addr),
    .ack_o        (io_ack),
    .rdata_o      (io_link_rdata),
    .bram_en_o    (io_en_o),
    .bram_we_o    (io_we_o),
    .bram_addr_o  (io_addr_o),
    .bram_wmask_o (io_wmask_o),
    .bram_wdata_o (io_wdata_o),
    .bram_rdata_i (io_rdata_i)
  );

endmodule

/* verif/core_mem_wrapper_properties.sv */
// ------------------------------
// Handshake and BRAM enable rules
// for the memory wrapper
// ------------------------------

`timescale 1ns/1ps

module core_mem_wrapper_properties (
  input logic clk_i,
  input logic rst_i,
  input logic req_i,
  input logic ack_i,
  input logic mem_en_i,
  input logic io_en_i
);

  en_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mem_en_i && io_en_i))
    else $error("mem_en_o and io_en_o high in the same cycle");

  mem_en_single: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_en_i |=> !mem_en_i)
    else $error("mem_en_o high for more than one cycle");

  io_en_single: assert property (@(posedge clk_i) disable iff (rst_i)
    io_en_i |=> !io_en_i)
    else $error("io_en_o high for more than one cycle");

  // Rise and fall are judged against req_i at the edge that caused them
  ack_rise: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i))
    else $error("ack_o rose without req_i high");

  ack_fall: assert property (@(posedge clk_i) disable iff (rst_i)
    $fell(ack_i) |-> !$past(req_i))
    else $error("ack_o fell while req_i was still high");

endmodule

bind core_mem_wrapper core_mem_wrapper_properties props (
  .clk_i,
  .rst_i,
  .req_i,
  .ack_i    (ack_o),
  .mem_en_i (mem_en_o),
  .io_en_i  (io_en_o)
);

/* verif/tb_core_mem_wrapper.sv */
// ------------------------------
// Testbench for the memory wrapper
// with two behavioral BRAM models
// ------------------------------

`timescale 1ns/1ps

module tb_core_mem_wrapper import bus_pkg::*; ();

  localparam addr_t       MemBase       = 32'h8000_0000;
  localparam addr_t       MemMask       = 32'h0000_FFFF;
  localparam addr_t       IoBase        = 32'h8001_0000;
  localparam addr_t       IoMask        = 32'h0000_003F;
  localparam int unsigned BramAddrWidth = 13;
  localparam int unsigned BramDepth     = 1 << BramAddrWidth;
  localparam int          ClkPeriod     = 10;
  localparam int          AckLimit      = 16;
  localparam int          MemWords      = 8;
  localparam int          MaskRounds    = 4;
  localparam int          IoWords       = 4;
  localparam int          NumAccesses   = 2 * MemWords + 2 * MaskRounds + 2 * IoWords + 10;

  logic                     clk;
  logic                     rst;
  logic                     req;
  bus_req_t                 req_data;
  logic                     ack;
  bus_rsp_t                 rsp;
  logic                     mem_en;
  logic                     mem_we;
  logic [BramAddrWidth-1:0] mem_addr;
  wmask_t                   mem_wmask;
  data_t                    mem_wdata;
  data_t                    mem_rdata;
  logic                     io_en;
  logic                     io_we;
  logic [BramAddrWidth-1:0] io_addr;
  wmask_t                   io_wmask;
  data_t                    io_wdata;
  data_t                    io_rdata;

  data_t       mem_model  [BramDepth];
  data_t       io_model   [BramDepth];
  data_t       mem_shadow [BramDepth];
  data_t       io_shadow  [BramDepth];
  int          mem_en_count = 0;
  int          io_en_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  logic [31:0] lfsr_state;

  core_mem_wrapper dut (
    .clk_i       (clk),
    .rst_i       (rst),
    .req_i       (req),
    .req_data_i  (req_data),
    .ack_o       (ack),
    .rsp_o       (rsp),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wmask_o (mem_wmask),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata),
    .io_en_o     (io_en),
    .io_we_o     (io_we),
    .io_addr_o   (io_addr),
    .io_wmask_o  (io_wmask),
    .io_wdata_o  (io_wdata),
    .io_rdata_i  (io_rdata)
  );

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input wmask_t mask);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 8; b++)
      if (mask[b])
        merged[b*8 +: 8] = new_word[b*8 +: 8];
    return merged;
  endfunction

  // BRAM models with one-cycle read latency
  always @(posedge clk)
  begin
    if (mem_en)
    begin
      mem_rdata <= mem_model[mem_addr];
      if (mem_we)
        mem_model[mem_addr] <= merge_bytes(mem_model[mem_addr], mem_wdata, mem_wmask);
      mem_en_count <= mem_en_count + 1;
    end
    if (io_en)
    begin
      io_rdata <= io_model[io_addr];
      if (io_we)
        io_model[io_addr] <= merge_bytes(io_model[io_addr], io_wdata, io_wmask);
      io_en_count <= io_en_count + 1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0])
      return (state >> 1) ^ 32'h8020_0003;
    return state >> 1;
  endfunction

  task automatic random_bits(input int count, output logic [63:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      value = {value[62:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Every address bit outside the mask has to equal the base
  function automatic logic in_window(input addr_t addr, input addr_t base, input addr_t mask);
    for (int b = 0; b < $bits(addr_t); b++)
      if (!mask[b] && (addr[b] !== base[b]))
        return 1'b0;
    return 1'b1;
  endfunction

  function automatic link_e expected_link(input addr_t addr);
    if (in_window(addr, IoBase, IoMask))
      return LINK_IO;
    if (in_window(addr, MemBase, MemMask))
      return LINK_MEM;
    return LINK_NONE;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    check_count++;
    assert (got === expected)
    else
    begin
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      error_count++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1)
    else
    begin
      $display("error at %0t ns: %s", $time, what);
      error_count++;
    end
  endtask

  // One four-phase access, held for hold_cycles after ack
  task automatic do_access(input logic we, input addr_t addr, input wmask_t wmask,
                           input data_t wdata, input int hold_cycles);
    link_e    link;
    int       word;
    int       mem_before;
    int       io_before;
    int       latency;
    data_t    expected;
    bus_rsp_t held;
    link = expected_link(addr);
    word = int'((addr >> 3) & (BramDepth - 1));
    @(posedge clk);
    #1;
    mem_before = mem_en_count;
    io_before = io_en_count;
    req_data.we = we;
    req_data.addr = addr;
    req_data.wmask = wmask;
    req_data.wdata = wdata;
    req = 1'b1;
    @(posedge clk);
    #1;
    latency = 0;
    while (!ack && latency < AckLimit)
    begin
      @(posedge clk);
      #1;
      latency++;
    end
    check_true(ack, "no ack from the DUT after a request");
    check_value("ack latency", 64'(latency), (link == LINK_NONE) ? 64'd1 : 64'd3);
    case (link)
      LINK_MEM: expected = mem_shadow[word];
      LINK_IO:  expected = io_shadow[word];
      default:  expected = '0;
    endcase
    check_value("rsp_o.err", 64'(rsp.err), 64'(link == LINK_NONE));
    if (!we || link == LINK_NONE)
      check_value("rsp_o.rdata", rsp.rdata, expected);
    if (we && link == LINK_MEM)
      mem_shadow[word] = merge_bytes(mem_shadow[word], wdata, wmask);
    if (we && link == LINK_IO)
      io_shadow[word] = merge_bytes(io_shadow[word], wdata, wmask);
    held = rsp;
    repeat (hold_cycles)
    begin
      @(posedge clk);
      #1;
      check_true(ack, "ack_o dropped while req_i was still high");
      check_true(rsp === held, "rsp_o changed while ack_o was high");
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    check_true(!ack, "ack_o still high one cycle after req_i was sampled low");
    check_value("mem_en_o pulses", 64'(mem_en_count - mem_before), 64'(link == LINK_MEM));
    check_value("io_en_o pulses", 64'(io_en_count - io_before), 64'(link == LINK_IO));
  endtask

  task automatic test_reset();
    check_value("ack_o", 64'(ack), 64'd0);
    check_value("mem_en_o", 64'(mem_en), 64'd0);
    check_value("io_en_o", 64'(io_en), 64'd0);
  endtask

  task automatic test_mem_rw();
    addr_t       addrs [MemWords];
    logic [63:0] bits;
    for (int i = 0; i < MemWords; i++)
    begin
      random_bits(BramAddrWidth, bits);
      addrs[i] = MemBase | addr_t'(bits << 3);
      random_bits(64, bits);
      do_access(1'b1, addrs[i], 8'hFF, bits, 0);
    end
    for (int i = 0; i < MemWords; i++)
      do_access(1'b0, addrs[i], 8'h00, '0, 0);
  endtask

  task automatic test_byte_masks();
    addr_t       addr;
    wmask_t      mask;
    logic [63:0] bits;
    for (int r = 0; r < MaskRounds; r++)
    begin
      random_bits(BramAddrWidth, bits);
      addr = MemBase | addr_t'(bits << 3);
      random_bits(8, bits);
      mask = bits[7:0];
      if (mask == 8'hFF || mask == 8'h00)
        mask = 8'h5A;
      random_bits(64, bits);
      do_access(1'b1, addr, mask, bits, 0);
      do_access(1'b0, addr, 8'h00, '0, 0);
    end
  endtask

  task automatic test_io_routing();
    addr_t       addrs [IoWords];
    logic [63:0] bits;
    int          changed;
    for (int i = 0; i < IoWords; i++)
    begin
      random_bits(3, bits);
      addrs[i] = IoBase | addr_t'(bits << 3);
      random_bits(64, bits);
      do_access(1'b1, addrs[i], 8'hFF, bits, 0);
    end
    for (int i = 0; i < IoWords; i++)
      do_access(1'b0, addrs[i], 8'h00, '0, 0);
    changed = 0;
    for (int w = 0; w < BramDepth; w++)
      if (mem_model[w] !== mem_shadow[w])
        changed++;
    check_value("memory words differing from expected", 64'(changed), 64'd0);
  endtask

  task automatic test_decode_error();
    do_access(1'b0, 32'h0000_1000, 8'h00, '0, 0);
    do_access(1'b1, 32'h8001_0040, 8'hFF, 64'h1234_5678_9abc_def0, 0);
    do_access(1'b0, 32'h7FFF_FFF8, 8'h00, '0, 0);
    do_access(1'b1, 32'hFFFF_0000, 8'h0F, 64'hdead_beef_0bad_f00d, 0);
  endtask

  task automatic test_handshake();
    logic [63:0] bits;
    random_bits(64, bits);
    do_access(1'b0, MemBase | 32'h100, 8'h00, '0, 5);
    do_access(1'b1, IoBase | 32'h8, 8'hFF, bits, 4);
    // Back-to-back accesses across both links
    random_bits(64, bits);
    do_access(1'b1, MemBase | 32'h200, 8'hFF, bits, 0);
    do_access(1'b0, IoBase | 32'h8, 8'h00, '0, 0);
    do_access(1'b0, MemBase | 32'h200, 8'h00, '0, 0);
    do_access(1'b0, MemBase | 32'h100, 8'h00, '0, 0);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial
  begin
    #((NumAccesses * 20 + 200) * ClkPeriod);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    rst = 1'b1;
    req = 1'b0;
    req_data = '0;
    mem_rdata = '0;
    io_rdata = '0;
    lfsr_state = 32'hec33;
    for (int w = 0; w < BramDepth; w++)
    begin
      mem_model[w] = {32'(w) ^ 32'h5a5a_0000, ~32'(w)};
      io_model[w] = {~32'(w), 32'(w) ^ 32'h0f0f_c3c3};
      mem_shadow[w] = mem_model[w];
      io_shadow[w] = io_model[w];
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;
    test_reset();
    test_mem_rw();
    test_byte_masks();
    test_io_routing();
    test_decode_error();
    test_handshake();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* flist.f */
logic/bus_pkg.sv
logic/bram_pkg.sv
logic/bus_socket_1n.sv
logic/bram_bridge.sv
logic/core_mem_wrapper.sv
verif/core_mem_wrapper_properties.sv
verif/tb_core_mem_wrapper.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory wrapper testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_core_mem_wrapper -f flist.f -o sim_tb > build.log 2>&1 \
  || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > "$LOG" 2>&1

grep -qF '** FAIL **' "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -qF '** PASS **' "$LOG" || { echo "simulation ended without a result, see $LOG"; exit 1; }
echo "simulation passed"
exit 0
